// ==== Makefile ====
# Verilator build and run for the data-memory stage

VERILATOR ?= verilator
TOP       ?= mem_subsystem_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
PASS_TEXT ?= TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# The grep decides the exit status of the run
run: build
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== src/core_pkg.sv ====
package core_pkg;

    // Datapath widths
    localparam int WORD_SIZE = 32;
    localparam int ADDR_SIZE = 32;

    // Register file index
    localparam int REG_SIZE = 5;

    // Access size of a load or store
    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10
    } memop_data_type_e;

endpackage

// ==== src/dcache_data.sv ====
`timescale 1ns/1ps

module dcache_data #(
    parameter int NUM_LINES = 16
) (
    input logic clk_i,
    input logic reset_i,

    dcache_data_if.array dcache
);

    localparam int LANE_SIZE = dcache_pkg::DCACHE_LANE_SIZE;
    localparam int BYTE_SIZE = dcache_pkg::DCACHE_BYTE_SIZE;
    localparam int WORD_SIZE = core_pkg::WORD_SIZE;
    localparam int NUM_BYTES = dcache_pkg::SB_MASK_SIZE;

    logic [LANE_SIZE-1:0] lanes [NUM_LINES];

    logic [BYTE_SIZE-3:0] word_sel;
    logic [LANE_SIZE-1:0] cur_lane;
    logic [LANE_SIZE-1:0] merged_lane;

    assign word_sel = dcache.byte_off[BYTE_SIZE-1:2];
    assign cur_lane = lanes[dcache.index];

    // Read port
    always_comb begin
        if (dcache.rd) begin
            dcache.rd_word = cur_lane[word_sel*WORD_SIZE +: WORD_SIZE];
        end else begin
            dcache.rd_word = '0;
        end
    end

    // Store drain only touches the enabled bytes of one word
    always_comb begin
        merged_lane = cur_lane;
        for (int b = 0; b < NUM_BYTES; b++) begin
            if (dcache.wr_mask[b]) begin
                merged_lane[(word_sel*NUM_BYTES + b)*8 +: 8] = dcache.wr_word[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < NUM_LINES; i++) begin
                lanes[i] <= '0;
            end
        end else if (dcache.refill) begin
            // Refill replaces the whole lane
            lanes[dcache.index] <= dcache.lane;
        end else if (dcache.wr) begin
            lanes[dcache.index] <= merged_lane;
        end
    end

    // The stage must never schedule a drain on top of a refill
    refill_wr_exclusive: assert property (
        @(posedge clk_i) disable iff (reset_i)
        !(dcache.refill && dcache.wr)
    ) else $error("dcache_data: refill and store write in the same cycle");

endmodule

// ==== src/dcache_data_if.sv ====
`timescale 1ns/1ps

interface dcache_data_if #(
    parameter int NUM_LINES = 16
) ();

    localparam int INDEX_SIZE = $clog2(NUM_LINES);

    logic                                   rd;
    logic                                   wr;
    logic                                   refill;
    logic [INDEX_SIZE-1:0]                  index;
    logic [dcache_pkg::DCACHE_BYTE_SIZE-1:0] byte_off;
    logic [dcache_pkg::SB_MASK_SIZE-1:0]    wr_mask;
    logic [core_pkg::WORD_SIZE-1:0]         wr_word;
    logic [dcache_pkg::DCACHE_LANE_SIZE-1:0] lane;

    // Word picked out of the lane by index and byte_off
    logic [core_pkg::WORD_SIZE-1:0]         rd_word;

    modport stage (
        output rd, wr, refill, index, byte_off, wr_mask, wr_word, lane,
        input  rd_word
    );

    modport array (
        input  rd, wr, refill, index, byte_off, wr_mask, wr_word, lane,
        output rd_word
    );

endinterface

// ==== src/dcache_pkg.sv ====
package dcache_pkg;

    // One lane holds four words
    localparam int DCACHE_LANE_SIZE = 128;

    // Byte offset inside a lane
    localparam int DCACHE_BYTE_SIZE = 4;

    localparam int DCACHE_WORDS_PER_LANE = DCACHE_LANE_SIZE / core_pkg::WORD_SIZE;

    // Word address and byte mask of a buffered store
    localparam int SB_ADDR_SIZE = core_pkg::ADDR_SIZE - 2;
    localparam int SB_MASK_SIZE = core_pkg::WORD_SIZE / 8;

    // Pending store, data already shifted to its byte lanes
    typedef struct packed {
        logic [SB_ADDR_SIZE-1:0]        addr;
        logic [SB_MASK_SIZE-1:0]        mask;
        logic [core_pkg::WORD_SIZE-1:0] data;
        core_pkg::memop_data_type_e     memop_type;
    } sb_entry_t;

endpackage

// ==== src/mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage #(
    parameter int NUM_LINES = 16
) (
    input  logic                                    clk_i,
    input  logic                                    reset_i,
    // Memory operation
    input  logic                                    memop_rd_i,
    input  logic                                    memop_wr_i,
    input  logic [core_pkg::ADDR_SIZE-1:0]          memop_addr_i,
    input  core_pkg::memop_data_type_e              memop_type_i,
    input  logic                                    memop_sign_ext_i,
    input  logic [core_pkg::WORD_SIZE-1:0]          store_data_i,
    // Register file
    input  logic                                    rf_we_i,
    input  logic [core_pkg::REG_SIZE-1:0]           rf_waddr_i,
    // Refill from MMU
    input  logic                                    refill_i,
    input  logic [$clog2(NUM_LINES)-1:0]            refill_index_i,
    input  logic [dcache_pkg::DCACHE_LANE_SIZE-1:0] refill_lane_i,
    // Writeback
    output logic [core_pkg::WORD_SIZE-1:0]          wb_data_o,
    output logic                                    rf_we_o,
    output logic [core_pkg::REG_SIZE-1:0]           rf_waddr_o,
    output logic                                    stall_o,
    // Write-through
    output logic                                    mem_wr_o,
    output logic [core_pkg::ADDR_SIZE-1:0]          mem_wr_addr_o,
    output logic [core_pkg::WORD_SIZE-1:0]          mem_wr_data_o,
    output core_pkg::memop_data_type_e              mem_wr_type_o,

    dcache_data_if.stage dcache,
    sb_if.stage          sbuf
);

    localparam int IDX_W     = $clog2(NUM_LINES);
    localparam int BYTE_SIZE = dcache_pkg::DCACHE_BYTE_SIZE;

    logic [dcache_pkg::SB_MASK_SIZE-1:0] byte_mask;
    logic [core_pkg::WORD_SIZE-1:0]      store_word;
    logic [core_pkg::WORD_SIZE-1:0]      src_word;
    logic [core_pkg::WORD_SIZE-1:0]      shifted;
    logic [core_pkg::WORD_SIZE-1:0]      load_data;
    logic                                load_acc;
    logic                                store_acc;
    logic                                drain;

    // Lowest enabled byte gives the byte address of a drained store
    function automatic logic [1:0] mask_offset(input logic [3:0] mask);
        if (mask[0]) return 2'd0;
        if (mask[1]) return 2'd1;
        if (mask[2]) return 2'd2;
        return 2'd3;
    endfunction

    always_comb begin
        unique case (memop_type_i)
            core_pkg::BYTE: byte_mask = 4'b0001 << memop_addr_i[1:0];
            core_pkg::HALF: byte_mask = 4'b0011 << memop_addr_i[1:0];
            default:        byte_mask = 4'b1111;
        endcase
    end

    assign store_word = store_data_i << {memop_addr_i[1:0], 3'b000};

    // A load colliding with a refill cannot use the array port either
    assign stall_o   = (memop_wr_i && sbuf.full) ||
                       (memop_rd_i && (sbuf.conflict || refill_i));
    assign load_acc  = memop_rd_i && !stall_o;
    assign store_acc = memop_wr_i && !stall_o;
    assign drain     = !refill_i && !load_acc && !sbuf.empty;

    // Cache array: refill, then load, then drain
    assign dcache.rd       = load_acc;
    assign dcache.wr       = drain;
    assign dcache.refill   = refill_i;
    assign dcache.index    = refill_i ? refill_index_i :
                             drain    ? sbuf.head.addr[BYTE_SIZE-2 +: IDX_W] :
                                        memop_addr_i[BYTE_SIZE +: IDX_W];
    assign dcache.byte_off = drain ? {sbuf.head.addr[BYTE_SIZE-3:0], 2'b00} :
                                     memop_addr_i[BYTE_SIZE-1:0];
    assign dcache.wr_mask  = sbuf.head.mask;
    assign dcache.wr_word  = sbuf.head.data;
    assign dcache.lane     = refill_lane_i;

    // Store buffer
    assign sbuf.push        = store_acc;
    assign sbuf.push_entry  = '{addr: memop_addr_i[core_pkg::ADDR_SIZE-1:2],
                                mask: byte_mask,
                                data: store_word,
                                memop_type: memop_type_i};
    assign sbuf.lookup_addr = memop_addr_i[core_pkg::ADDR_SIZE-1:2];
    assign sbuf.lookup_mask = byte_mask;
    assign sbuf.drain       = drain;

    // Buffered data is younger than the array
    assign src_word = sbuf.hit ? sbuf.fwd_word : dcache.rd_word;
    assign shifted  = src_word >> {memop_addr_i[1:0], 3'b000};

    always_comb begin
        unique case (memop_type_i)
            core_pkg::BYTE: load_data = {{24{memop_sign_ext_i & shifted[7]}}, shifted[7:0]};
            core_pkg::HALF: load_data = {{16{memop_sign_ext_i & shifted[15]}}, shifted[15:0]};
            default:        load_data = shifted;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rf_we_o  <= 1'b0;
            mem_wr_o <= 1'b0;
        end else begin
            rf_we_o  <= rf_we_i && !stall_o;
            mem_wr_o <= drain;
        end
    end

    always_ff @(posedge clk_i) begin
        wb_data_o  <= load_data;
        rf_waddr_o <= rf_waddr_i;
        if (drain) begin
            mem_wr_addr_o <= {sbuf.head.addr, mask_offset(sbuf.head.mask)};
            mem_wr_data_o <= sbuf.head.data;
            mem_wr_type_o <= sbuf.head.memop_type;
        end
    end

    rd_wr_exclusive: assert property (
        @(posedge clk_i) disable iff (reset_i)
        !(memop_rd_i && memop_wr_i)
    ) else $error("mem_stage: read and write strobes together");

    no_push_when_full: assert property (
        @(posedge clk_i) disable iff (reset_i)
        sbuf.push |-> !sbuf.full
    ) else $error("mem_stage: push into a full store buffer");

    access_aligned: assert property (
        @(posedge clk_i) disable iff (reset_i)
        (memop_rd_i || memop_wr_i) |->
            ((memop_type_i != core_pkg::HALF || memop_addr_i[0] == 1'b0) &&
             (memop_type_i != core_pkg::WORD || memop_addr_i[1:0] == 2'b00))
    ) else $error("mem_stage: misaligned access");

endmodule

// ==== src/mem_subsystem_top.sv ====
`timescale 1ns/1ps

module mem_subsystem_top #(
    parameter int NUM_LINES = 16,
    parameter int SB_DEPTH  = 4
) (
    input  logic                                    clk_i,
    input  logic                                    reset_i,
    input  logic                                    memop_rd_i,
    input  logic                                    memop_wr_i,
    input  logic [core_pkg::ADDR_SIZE-1:0]          memop_addr_i,
    input  core_pkg::memop_data_type_e              memop_type_i,
    input  logic                                    memop_sign_ext_i,
    input  logic [core_pkg::WORD_SIZE-1:0]          store_data_i,
    input  logic                                    rf_we_i,
    input  logic [core_pkg::REG_SIZE-1:0]           rf_waddr_i,
    input  logic                                    refill_i,
    input  logic [$clog2(NUM_LINES)-1:0]            refill_index_i,
    input  logic [dcache_pkg::DCACHE_LANE_SIZE-1:0] refill_lane_i,
    output logic [core_pkg::WORD_SIZE-1:0]          wb_data_o,
    output logic                                    rf_we_o,
    output logic [core_pkg::REG_SIZE-1:0]           rf_waddr_o,
    output logic                                    stall_o,
    output logic                                    mem_wr_o,
    output logic [core_pkg::ADDR_SIZE-1:0]          mem_wr_addr_o,
    output logic [core_pkg::WORD_SIZE-1:0]          mem_wr_data_o,
    output core_pkg::memop_data_type_e              mem_wr_type_o
);

    dcache_data_if #(.NUM_LINES(NUM_LINES)) dcache_bus ();
    sb_if sb_bus ();

    mem_stage #(
        .NUM_LINES(NUM_LINES)
    ) u_mem_stage (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .memop_rd_i       (memop_rd_i),
        .memop_wr_i       (memop_wr_i),
        .memop_addr_i     (memop_addr_i),
        .memop_type_i     (memop_type_i),
        .memop_sign_ext_i (memop_sign_ext_i),
        .store_data_i     (store_data_i),
        .rf_we_i          (rf_we_i),
        .rf_waddr_i       (rf_waddr_i),
        .refill_i         (refill_i),
        .refill_index_i   (refill_index_i),
        .refill_lane_i    (refill_lane_i),
        .wb_data_o        (wb_data_o),
        .rf_we_o          (rf_we_o),
        .rf_waddr_o       (rf_waddr_o),
        .stall_o          (stall_o),
        .mem_wr_o         (mem_wr_o),
        .mem_wr_addr_o    (mem_wr_addr_o),
        .mem_wr_data_o    (mem_wr_data_o),
        .mem_wr_type_o    (mem_wr_type_o),
        .dcache           (dcache_bus.stage),
        .sbuf             (sb_bus.stage)
    );

    store_buffer #(
        .SB_DEPTH(SB_DEPTH)
    ) u_store_buffer (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .sbuf    (sb_bus.buffer)
    );

    dcache_data #(
        .NUM_LINES(NUM_LINES)
    ) u_dcache_data (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .dcache  (dcache_bus.array)
    );

endmodule

// ==== src/sb_if.sv ====
`timescale 1ns/1ps

interface sb_if ();

    // Stage side
    logic                                push;
    dcache_pkg::sb_entry_t               push_entry;
    logic [dcache_pkg::SB_ADDR_SIZE-1:0] lookup_addr;
    logic [dcache_pkg::SB_MASK_SIZE-1:0] lookup_mask;
    logic                                drain;

    // Buffer side
    logic                                hit;
    logic [core_pkg::WORD_SIZE-1:0]      fwd_word;
    logic                                conflict;
    logic                                full;
    logic                                empty;
    dcache_pkg::sb_entry_t               head;

    modport stage (
        output push, push_entry, lookup_addr, lookup_mask, drain,
        input  hit, fwd_word, conflict, full, empty, head
    );

    modport buffer (
        input  push, push_entry, lookup_addr, lookup_mask, drain,
        output hit, fwd_word, conflict, full, empty, head
    );

endinterface

// ==== src/store_buffer.sv ====
`timescale 1ns/1ps

module store_buffer #(
    parameter int SB_DEPTH = 4
) (
    input logic clk_i,
    input logic reset_i,

    sb_if.buffer sbuf
);

    localparam int PTR_W = (SB_DEPTH > 1) ? $clog2(SB_DEPTH) : 1;
    localparam int CNT_W = $clog2(SB_DEPTH + 1);

    dcache_pkg::sb_entry_t entries [SB_DEPTH];

    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;

    logic                  match_found;
    dcache_pkg::sb_entry_t match_entry;
    logic                  match_covers;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(SB_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign sbuf.full  = (count == CNT_W'(SB_DEPTH));
    assign sbuf.empty = (count == '0);
    assign sbuf.head  = entries[head];

    // Walk from oldest to youngest so the last match wins
    always_comb begin : lookup
        int slot;
        match_found = 1'b0;
        match_entry = '0;
        for (int i = 0; i < SB_DEPTH; i++) begin
            slot = (int'(head) + i) % SB_DEPTH;
            if (i < int'(count) && entries[slot].addr == sbuf.lookup_addr) begin
                match_found = 1'b1;
                match_entry = entries[slot];
            end
        end
    end

    assign match_covers = ((match_entry.mask & sbuf.lookup_mask) == sbuf.lookup_mask);

    // Partial cover means older bytes are mixed in, so the stage has to wait
    assign sbuf.hit      = match_found && match_covers;
    assign sbuf.conflict = match_found && !match_covers;
    assign sbuf.fwd_word = match_entry.data;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (sbuf.push) begin
                tail <= next_ptr(tail);
            end
            if (sbuf.drain) begin
                head <= next_ptr(head);
            end
            if (sbuf.push && !sbuf.drain) begin
                count <= count + 1'b1;
            end else if (!sbuf.push && sbuf.drain) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (sbuf.push) begin
            entries[tail] <= sbuf.push_entry;
        end
    end

    // Drain is only granted with something queued
    drain_not_empty: assert property (
        @(posedge clk_i) disable iff (reset_i)
        sbuf.drain |-> !sbuf.empty
    ) else $error("store_buffer: drain while empty");

endmodule

// ==== tb.f ====
src/core_pkg.sv
src/dcache_pkg.sv
src/dcache_data_if.sv
src/sb_if.sv
src/dcache_data.sv
src/store_buffer.sv
src/mem_stage.sv
src/mem_subsystem_top.sv
testbench/mem_subsystem_tb.sv

// ==== testbench/mem_subsystem_tb.sv ====
`timescale 1ns/1ps

module mem_subsystem_tb;

    localparam int NUM_LINES     = 16;
    localparam int SB_DEPTH      = 4;
    localparam int CLK_PERIOD    = 40;
    localparam int RESET_CYCLES  = 8;
    localparam int ZERO_LOADS    = 12;
    localparam int BLOCKS        = 6;
    localparam int OPS_PER_BLOCK = 80;
    localparam int TOTAL_CYCLES  = RESET_CYCLES + ZERO_LOADS +
                                   BLOCKS * (OPS_PER_BLOCK + SB_DEPTH + 2 + 1 + 4) +
                                   SB_DEPTH + 4;
    localparam int CYCLE_LIMIT   = 4 * TOTAL_CYCLES;

    logic         clk_i;
    logic         reset_i;
    logic         memop_rd_i;
    logic         memop_wr_i;
    logic [31:0]  memop_addr_i;
    core_pkg::memop_data_type_e memop_type_i;
    logic         memop_sign_ext_i;
    logic [31:0]  store_data_i;
    logic         rf_we_i;
    logic [4:0]   rf_waddr_i;
    logic         refill_i;
    logic [3:0]   refill_index_i;
    logic [127:0] refill_lane_i;
    logic [31:0]  wb_data_o;
    logic         rf_we_o;
    logic [4:0]   rf_waddr_o;
    logic         stall_o;
    logic         mem_wr_o;
    logic [31:0]  mem_wr_addr_o;
    logic [31:0]  mem_wr_data_o;
    core_pkg::memop_data_type_e mem_wr_type_o;

    // Byte image of the four lines in use, stores applied in program order
    logic [7:0]  model_mem [64];
    logic [31:0] lfsr_state = 32'h75f2;
    logic        checking;
    logic        exp_we;
    logic [4:0]  exp_waddr;
    logic [31:0] exp_data;
    logic [31:0] exp_wr_addr [$];
    logic [31:0] exp_wr_data [$];
    logic [1:0]  exp_wr_type [$];
    int          stall_count;
    int          cycles;
    string       cur_test;

    mem_subsystem_top #(.NUM_LINES(NUM_LINES), .SB_DEPTH(SB_DEPTH)) UUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [3:0] size_mask(input logic [5:0] addr, input logic [1:0] typ);
        if (typ == 2'd0) return 4'b0001 << addr[1:0];
        if (typ == 2'd1) return 4'b0011 << addr[1:0];
        return 4'b1111;
    endfunction

    function automatic logic [31:0] load_ref(input logic [5:0] addr, input logic [1:0] typ,
                                             input logic sext);
        logic [5:0]  base;
        logic [31:0] word;
        base = {addr[5:2], 2'b00};
        word = {model_mem[base + 3], model_mem[base + 2], model_mem[base + 1], model_mem[base]};
        word = word >> (8 * addr[1:0]);
        if (typ == 2'd0) return {{24{sext & word[7]}}, word[7:0]};
        if (typ == 2'd1) return {{16{sext & word[15]}}, word[15:0]};
        return word;
    endfunction

    // Pending stores are the ones not yet seen on the write-through port
    function automatic logic stall_ref(input logic rd, input logic [5:0] addr,
                                       input logic [1:0] typ);
        logic       found;
        logic [3:0] need;
        logic [3:0] have;
        found = 1'b0;
        have  = '0;
        need  = size_mask(addr, typ);
        if (!rd) return exp_wr_addr.size() == SB_DEPTH;
        // Youngest store to the same word decides
        for (int i = 0; i < exp_wr_addr.size(); i++) begin
            if (exp_wr_addr[i][5:2] == addr[5:2]) begin
                found = 1'b1;
                have  = size_mask(exp_wr_addr[i][5:0], exp_wr_type[i]);
            end
        end
        return found && ((have & need) != need);
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("** Error [%s]: expected %h, actual %h", name, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    task automatic publish(input logic we, input logic [4:0] waddr, input logic [31:0] data);
        exp_we    = we;
        exp_waddr = waddr;
        exp_data  = data;
    endtask

    task automatic drive_idle();
        @(negedge clk_i);
        memop_rd_i = 1'b0;
        memop_wr_i = 1'b0;
        refill_i   = 1'b0;
        rf_we_i    = 1'b0;
        #1;
        publish(1'b0, '0, '0);
    endtask

    task automatic drive_access(input logic rd, input logic [5:0] addr, input logic [1:0] typ,
                                input logic sext, input logic [31:0] data,
                                input logic [4:0] waddr);
        logic [31:0] shifted;
        logic [3:0]  mask;
        @(negedge clk_i);
        memop_rd_i       = rd;
        memop_wr_i       = !rd;
        memop_addr_i     = {26'b0, addr};
        memop_type_i     = core_pkg::memop_data_type_e'(typ);
        memop_sign_ext_i = sext;
        store_data_i     = data;
        rf_we_i          = rd;
        rf_waddr_i       = waddr;
        refill_i         = 1'b0;
        #1;
        // Access is held until the stage takes it
        check({cur_test, " stall"}, 32'(stall_ref(rd, addr, typ)), 32'(stall_o));
        while (stall_o) begin
            stall_count++;
            publish(1'b0, '0, '0);
            @(negedge clk_i);
            #1;
            check({cur_test, " stall"}, 32'(stall_ref(rd, addr, typ)), 32'(stall_o));
        end
        if (rd) begin
            publish(1'b1, waddr, load_ref(addr, typ, sext));
        end else begin
            publish(1'b0, '0, '0);
            shifted = data << (8 * addr[1:0]);
            mask    = size_mask(addr, typ);
            for (int b = 0; b < 4; b++) begin
                if (mask[b]) begin
                    model_mem[{addr[5:2], 2'b00} + b] = shifted[8*b +: 8];
                end
            end
            exp_wr_addr.push_back({26'b0, addr});
            exp_wr_data.push_back(shifted);
            exp_wr_type.push_back(typ);
        end
    endtask

    task automatic random_access();
        logic       rd;
        logic [1:0] typ;
        logic [5:0] addr;
        rd   = take_bits(1) != 0;
        typ  = 2'(take_bits(2));
        addr = 6'(take_bits(6));
        if (typ == 2'd3) typ = 2'd2;
        if (typ == 2'd1) addr[0] = 1'b0;
        if (typ == 2'd2) addr[1:0] = 2'b00;
        drive_access(rd, addr, typ, take_bits(1) != 0, take_bits(32), 5'(take_bits(5)));
    endtask

    task automatic drive_refill(input logic [1:0] line, input logic [127:0] lane);
        @(negedge clk_i);
        memop_rd_i     = 1'b0;
        memop_wr_i     = 1'b0;
        rf_we_i        = 1'b0;
        refill_i       = 1'b1;
        refill_index_i = {2'b00, line};
        refill_lane_i  = lane;
        #1;
        publish(1'b0, '0, '0);
        for (int b = 0; b < 16; b++) model_mem[{line, 4'b0000} + b] = lane[8*b +: 8];
    endtask

    // Outputs settle after the rising edge
    initial begin
        forever begin
            @(posedge clk_i);
            #2;
            if (checking) begin
                check({cur_test, " rf_we"}, 32'(exp_we), 32'(rf_we_o));
                if (exp_we) begin
                    check({cur_test, " rf_waddr"}, 32'(exp_waddr), 32'(rf_waddr_o));
                    check({cur_test, " wb_data"}, exp_data, wb_data_o);
                end
                if (mem_wr_o && exp_wr_addr.size() == 0) begin
                    $display("Write-through seen with no accepted store left to match");
                    $display("TEST RESULT: FAIL");
                    $fatal(1, "unexpected write-through");
                end else if (mem_wr_o) begin
                    check({cur_test, " mem_wr_addr"}, exp_wr_addr.pop_front(), mem_wr_addr_o);
                    check({cur_test, " mem_wr_data"}, exp_wr_data.pop_front(), mem_wr_data_o);
                    check({cur_test, " mem_wr_type"}, 32'(exp_wr_type.pop_front()),
                          32'(mem_wr_type_o));
                end
            end
        end
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk_i);
            cycles++;
            if (cycles >= CYCLE_LIMIT) begin
                $display("Run hung: no progress after %0d cycles", cycles);
                $display("TEST RESULT: FAIL");
                $fatal(1, "timeout");
            end
        end
    end

    initial begin
        logic [1:0]   line;
        logic [127:0] lane;
        reset_i = 1'b1;
        memop_rd_i = 1'b0;
        memop_wr_i = 1'b0;
        memop_addr_i = '0;
        memop_type_i = core_pkg::WORD;
        memop_sign_ext_i = 1'b0;
        store_data_i = '0;
        rf_we_i = 1'b0;
        rf_waddr_i = '0;
        refill_i = 1'b0;
        refill_index_i = '0;
        refill_lane_i = '0;
        checking = 1'b0;
        stall_count = 0;
        cur_test = "reset_loads";
        publish(1'b0, '0, '0);
        for (int i = 0; i < 64; i++) model_mem[i] = 8'h00;
        repeat (RESET_CYCLES) @(negedge clk_i);
        reset_i  = 1'b0;
        checking = 1'b1;
        for (int i = 0; i < ZERO_LOADS; i++) begin
            drive_access(1'b1, 6'(i * 5) & ~6'(i % 3 == 2 ? 3 : i % 3), 2'(i % 3), i[0],
                         '0, 5'(i + 1));
        end
        for (int blk = 0; blk < BLOCKS; blk++) begin
            cur_test = "random_mix";
            repeat (OPS_PER_BLOCK) random_access();
            // Let the buffer drain before the lane is replaced
            cur_test = "refill";
            repeat (SB_DEPTH + 2) drive_idle();
            line = 2'(take_bits(2));
            lane = {take_bits(32), take_bits(32), take_bits(32), take_bits(32)};
            drive_refill(line, lane);
            for (int w = 0; w < 4; w++) begin
                drive_access(1'b1, {line, 2'(w), 2'b00}, 2'd2, 1'b0, '0, 5'(w + 8));
            end
        end
        cur_test = "final_drain";
        repeat (SB_DEPTH + 2) drive_idle();
        @(posedge clk_i);
        #5;
        check("pending write-through", 32'd0, 32'(exp_wr_addr.size()));
        check("stall seen", 32'd1, 32'(stall_count > 0));
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule
